// File: verilog.f
src/aes_pkg.sv
src/aes_sbox_word.sv
src/aes_key_schedule.sv
src/aes_block_datapath.sv
src/aes_encipher_ctrl.sv
src/aes_encipher_core.sv
tb/aes_encipher_properties.sv
tb/tb_aes_encipher_core.sv

// File: Bender.yml
package:
  name: aes_encipher_core

sources:
  - files:
      - src/aes_pkg.sv
      - src/aes_sbox_word.sv
      - src/aes_key_schedule.sv
      - src/aes_block_datapath.sv
      - src/aes_encipher_ctrl.sv
      - src/aes_encipher_core.sv
  - target: test
    files:
      - tb/aes_encipher_properties.sv
      - tb/tb_aes_encipher_core.sv

// File: tb/tb_aes_encipher_core.sv
// tb_aes_encipher_core
// directed FIPS-197 known-answer tests for the AES-128 encipher core
// also covers the 61-cycle latency, busy-time start and idle hold

`timescale 1ns/1ps
`default_nettype none

module tb_aes_encipher_core
  import aes_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int WAIT_LIMIT   = 200;
  // init cycle, then key + four sub + update per round
  localparam int LATENCY      = 1 + AES128_ROUNDS * 6;

  // --------------------
  // known answers
  // --------------------
  localparam logic [AES_BLOCK_W-1:0] KEY_C1   = 128'h000102030405060708090a0b0c0d0e0f;
  localparam logic [AES_BLOCK_W-1:0] BLOCK_C1 = 128'h00112233445566778899aabbccddeeff;
  localparam logic [AES_BLOCK_W-1:0] CT_C1    = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam logic [AES_BLOCK_W-1:0] KEY_B    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [AES_BLOCK_W-1:0] BLOCK_B  = 128'h3243f6a8885a308d313198a2e0370734;
  localparam logic [AES_BLOCK_W-1:0] CT_B     = 128'h3925841d02dc09fbdc118597196a0b32;
  localparam logic [AES_BLOCK_W-1:0] CT_ZERO  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

  logic                   clk;
  logic                   reset_n;
  logic                   next;
  logic [AES_BLOCK_W-1:0] key;
  logic [AES_BLOCK_W-1:0] block;
  logic                   ready;
  logic [AES_BLOCK_W-1:0] result;

  integer seed;
  int     error_count = 0;
  int     pass_count  = 0;
  int     fail_count  = 0;
  int     violations;

  aes_encipher_core aes_encipher_core_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .next    (next),
    .key     (key),
    .block   (block),
    .ready   (ready),
    .result  (result)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // helpers
  // --------------------
  // drive and sample 1 ns after the edge
  task automatic advance_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  function automatic logic [AES_BLOCK_W-1:0] random_block();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic check_block(input string name, input logic [AES_BLOCK_W-1:0] expected,
                             input logic [AES_BLOCK_W-1:0] actual);
    assert (actual === expected)
    else
    begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    assert (actual == expected)
    else
    begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
      error_count++;
    end
  endtask

  // one-cycle start pulse, key and block held through the init cycle
  task automatic start_block(input logic [AES_BLOCK_W-1:0] k,
                             input logic [AES_BLOCK_W-1:0] b);
    key   = k;
    block = b;
    next  = 1'b1;
    advance_cycles(1);
    next  = 1'b0;
  endtask

  // cycles counted from the edge that took next
  task automatic wait_ready(input string name, output int cycles);
    cycles = 0;
    while (!ready && cycles < WAIT_LIMIT)
    begin
      advance_cycles(1);
      cycles++;
    end
    if (!ready)
    begin
      $display("%s: ready still low after %0d cycles, gave up waiting", name, WAIT_LIMIT);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before)
    begin
      pass_count++;
      $display("test %s: pass", name);
    end
    else
    begin
      fail_count++;
      $display("test %s: fail with %0d errors", name, error_count - errors_before);
    end
  endtask

  // --------------------
  // tests
  // --------------------
  task automatic test_reset_state();
    int errs;
    errs = error_count;
    check_count("reset_state", 1, int'(ready));
    check_block("reset_state", '0, result);
    finish_test("reset_state", errs);
  endtask

  task automatic test_known_answer(input string name, input logic [AES_BLOCK_W-1:0] k,
                                   input logic [AES_BLOCK_W-1:0] b,
                                   input logic [AES_BLOCK_W-1:0] expected);
    int errs;
    int cycles;
    errs = error_count;
    start_block(k, b);
    wait_ready(name, cycles);
    check_count(name, LATENCY, cycles);
    check_block(name, expected, result);
    finish_test(name, errs);
  endtask

  // second start mid-run with another block must be ignored
  task automatic test_busy_start();
    int errs;
    int cycles;
    errs = error_count;
    start_block(KEY_C1, BLOCK_C1);
    check_count("busy_start", 0, int'(ready));
    cycles = 0;
    while (!ready && cycles < WAIT_LIMIT)
    begin
      if (cycles == 20)
      begin
        block = random_block();
        next  = 1'b1;
      end
      else
      begin
        next = 1'b0;
      end
      advance_cycles(1);
      cycles++;
    end
    next = 1'b0;
    if (!ready)
    begin
      $display("busy_start: ready still low after %0d cycles, gave up waiting", WAIT_LIMIT);
      error_count++;
    end
    check_count("busy_start", LATENCY, cycles);
    check_block("busy_start", CT_C1, result);
    finish_test("busy_start", errs);
  endtask

  // result held through idle cycles, inputs wander meanwhile
  task automatic test_back_to_back();
    int errs;
    int cycles;
    errs = error_count;
    start_block(KEY_C1, BLOCK_C1);
    wait_ready("back_to_back", cycles);
    check_block("back_to_back", CT_C1, result);
    for (int i = 0; i < 20; i++)
    begin
      key   = random_block();
      block = random_block();
      advance_cycles(1);
      check_count("back_to_back", 1, int'(ready));
      check_block("back_to_back", CT_C1, result);
    end
    start_block(KEY_B, BLOCK_B);
    wait_ready("back_to_back", cycles);
    check_count("back_to_back", LATENCY, cycles);
    check_block("back_to_back", CT_B, result);
    finish_test("back_to_back", errs);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial
  begin
    seed    = 32'hf585_7284;
    reset_n = 1'b0;
    next    = 1'b0;
    key     = '0;
    block   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n = 1'b1;

    test_reset_state();
    test_known_answer("fips_c1", KEY_C1, BLOCK_C1, CT_C1);
    test_known_answer("fips_b", KEY_B, BLOCK_B, CT_B);
    test_known_answer("all_zero", '0, '0, CT_ZERO);
    test_busy_start();
    test_back_to_back();
    advance_cycles(2);

    // bound FSM timing checks
    violations = aes_encipher_core_inst.u_ctrl.props_inst.violation_count;
    if (violations != 0)
    begin
      $display("control timing assertions failed %0d times", violations);
    end
    $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             pass_count + fail_count, pass_count, fail_count, error_count);
    if (fail_count == 0 && violations == 0)
    begin
      $display("ALL TESTS PASSED");
    end
    else
    begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/aes_encipher_properties.sv
// aes_encipher_properties
// control timing checks bound into the encipher FSM

`timescale 1ns/1ps
`default_nettype none

module aes_encipher_properties (
  input wire logic clk,
  input wire logic reset_n,
  input wire logic next,
  input wire logic ready,
  input wire logic key_cycle,
  input wire logic sub_we
);

  // bumped by every failing assertion
  int violation_count = 0;

  // accepted start drops ready on the next edge
  a_ready_falls: assert property (@(posedge clk) disable iff (!reset_n)
                                  (ready && next) |=> !ready)
    else
    begin
      $error("ready stayed high after an accepted start");
      violation_count++;
    end

  // one S-box user per cycle
  // key word first, then the four block words, then neither
  a_sbox_order: assert property (@(posedge clk) disable iff (!reset_n)
                                 key_cycle |=> sub_we ##1 sub_we ##1 sub_we ##1 sub_we
                                               ##1 (!sub_we && !key_cycle))
    else
    begin
      $error("S-box word cycles out of order after a key cycle");
      violation_count++;
    end

  // idle holds without a start
  a_idle_holds: assert property (@(posedge clk) disable iff (!reset_n)
                                 (ready && !next) |=> ready)
    else
    begin
      $error("ready dropped in idle without a start");
      violation_count++;
    end

endmodule

bind aes_encipher_ctrl aes_encipher_properties props_inst (
  .clk       (clk),
  .reset_n   (reset_n),
  .next      (next),
  .ready     (ready),
  .key_cycle (key_cycle),
  .sub_we    (sub_we)
);

`default_nettype wire

// File: src/aes_encipher_core.sv
// aes_encipher_core
// iterative AES-128 encipher, 61 cycles per block
// next starts a block, ready is high while result holds the ciphertext

`timescale 1ns/1ps
`default_nettype none

module aes_encipher_core
  import aes_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset_n,
  input  wire logic       next,
  input  wire aes_block_t key,
  input  wire aes_block_t block,
  output logic            ready,
  output aes_block_t      result
);

  // --------------------
  // control strobes
  // --------------------
  logic                   init_cycle;
  logic                   key_cycle;
  logic                   sub_we;
  logic [AES_SWORD_W-1:0] sword_sel;
  logic                   round_update;
  logic                   final_round;

  // shared S-box word and key paths
  logic [AES_WORD_W-1:0]  block_word;
  logic [AES_WORD_W-1:0]  key_word;
  logic [AES_WORD_W-1:0]  sbox_out;
  aes_block_t             round_key;

  aes_encipher_ctrl u_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .next         (next),
    .ready        (ready),
    .init_cycle   (init_cycle),
    .key_cycle    (key_cycle),
    .sub_we       (sub_we),
    .sword_sel    (sword_sel),
    .round_update (round_update),
    .final_round  (final_round)
  );

  aes_sbox_word u_sbox (
    .key_cycle  (key_cycle),
    .block_word (block_word),
    .key_word   (key_word),
    .sbox_out   (sbox_out)
  );

  aes_key_schedule u_key_schedule (
    .clk        (clk),
    .reset_n    (reset_n),
    .key        (key),
    .init_cycle (init_cycle),
    .key_cycle  (key_cycle),
    .sbox_out   (sbox_out),
    .round_key  (round_key),
    .key_word   (key_word)
  );

  aes_block_datapath u_datapath (
    .clk          (clk),
    .reset_n      (reset_n),
    .block        (block),
    .round_key    (round_key),
    .init_cycle   (init_cycle),
    .sub_we       (sub_we),
    .sword_sel    (sword_sel),
    .round_update (round_update),
    .final_round  (final_round),
    .sbox_out     (sbox_out),
    .block_word   (block_word),
    .result       (result)
  );

endmodule

`default_nettype wire

// File: src/aes_encipher_ctrl.sv
// aes_encipher_ctrl
// encipher FSM with the SubBytes word counter and the round counter
// one init cycle, then per round one key, four sub and one update cycle

`timescale 1ns/1ps
`default_nettype none

module aes_encipher_ctrl
  import aes_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset_n,
  input  wire logic                   next,
  output logic                        ready,
  output logic                        init_cycle,
  output logic                        key_cycle,
  output logic                        sub_we,
  output logic      [AES_SWORD_W-1:0] sword_sel,
  output logic                        round_update,
  output logic                        final_round
);

  logic [AES_ST_W-1:0]    state_reg;
  logic [AES_ST_W-1:0]    state_next;
  logic [AES_SWORD_W-1:0] sword_ctr;
  logic [AES_ROUND_W-1:0] round_ctr;
  logic                   last_word;

  // --------------------
  // state decode
  // --------------------
  assign ready        = (state_reg == AES_ST_IDLE);
  assign init_cycle   = (state_reg == AES_ST_INIT);
  assign key_cycle    = (state_reg == AES_ST_KEY);
  assign sub_we       = (state_reg == AES_ST_SUB);
  assign round_update = (state_reg == AES_ST_UPDATE);

  assign sword_sel   = sword_ctr;
  assign last_word   = (sword_ctr == AES_SWORD_W'(AES_NUM_WORDS - 1));
  // round_ctr counts finished rounds, so ten is at 9
  assign final_round = (round_ctr == AES_ROUND_W'(AES128_ROUNDS - 1));

  always_comb
  begin
    state_next = state_reg;
    case (state_reg)
      AES_ST_IDLE:
      begin
        // start only taken while idle
        if (next)
        begin
          state_next = AES_ST_INIT;
        end
      end
      AES_ST_INIT:   state_next = AES_ST_KEY;
      AES_ST_KEY:    state_next = AES_ST_SUB;
      AES_ST_SUB:
      begin
        if (last_word)
        begin
          state_next = AES_ST_UPDATE;
        end
      end
      AES_ST_UPDATE: state_next = final_round ? AES_ST_IDLE : AES_ST_KEY;
      default:       state_next = AES_ST_IDLE;
    endcase
  end

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_reg <= AES_ST_IDLE;
      sword_ctr <= '0;
      round_ctr <= '0;
    end
    else
    begin
      state_reg <= state_next;
      // word counter restarts every key cycle
      if (key_cycle)
      begin
        sword_ctr <= '0;
      end
      else if (sub_we)
      begin
        sword_ctr <= sword_ctr + 1'b1;
      end
      if (init_cycle)
      begin
        round_ctr <= '0;
      end
      else if (round_update)
      begin
        round_ctr <= round_ctr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/aes_block_datapath.sv
// aes_block_datapath
// AES state register with word-serial SubBytes write-back
// and a one-cycle ShiftRows, MixColumns, AddRoundKey update

`timescale 1ns/1ps
`default_nettype none

module aes_block_datapath
  import aes_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset_n,
  input  wire aes_block_t             block,
  input  wire aes_block_t             round_key,
  input  wire logic                   init_cycle,
  input  wire logic                   sub_we,
  input  wire logic [AES_SWORD_W-1:0] sword_sel,
  input  wire logic                   round_update,
  input  wire logic                   final_round,
  input  wire logic [AES_WORD_W-1:0]  sbox_out,
  output logic      [AES_WORD_W-1:0]  block_word,
  output aes_block_t                  result
);

  // --------------------
  // MixColumns helpers
  // --------------------

  // multiply by 3
  function automatic logic [7:0] gm3(input logic [7:0] a);
    return aes_xtime(a) ^ a;
  endfunction

  // one column, row 0 in the top byte
  function automatic logic [AES_WORD_W-1:0] mix_column(input logic [AES_WORD_W-1:0] col);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {aes_xtime(a0) ^ gm3(a1) ^ a2 ^ a3,
            a0 ^ aes_xtime(a1) ^ gm3(a2) ^ a3,
            a0 ^ a1 ^ aes_xtime(a2) ^ gm3(a3),
            gm3(a0) ^ a1 ^ a2 ^ aes_xtime(a3)};
  endfunction

  aes_block_t state_reg;
  aes_block_t shifted;
  aes_block_t mixed;
  aes_block_t round_out;

  // S-box sees the word picked by the word counter
  assign block_word = state_reg.w[sword_sel];
  assign result     = state_reg;

  // --------------------
  // round logic
  // --------------------
  always_comb
  begin
    // ShiftRows, row r rotates left by r columns
    for (int c = 0; c < AES_NUM_WORDS; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        shifted.b[4*c + r] = state_reg.b[4*((c + r) % AES_NUM_WORDS) + r];
      end
    end

    // MixColumns, bypassed in the final round
    for (int c = 0; c < AES_NUM_WORDS; c++)
    begin
      if (final_round)
      begin
        mixed.w[c] = shifted.w[c];
      end
      else
      begin
        mixed.w[c] = mix_column(shifted.w[c]);
      end
    end

    // AddRoundKey
    round_out = mixed ^ round_key;
  end

  // --------------------
  // state register
  // --------------------
  // init loads block ^ key, sub writes one word, update runs the round
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_reg <= '0;
    end
    else if (init_cycle)
    begin
      state_reg <= block ^ round_key;
    end
    else if (sub_we)
    begin
      state_reg.w[sword_sel] <= sbox_out;
    end
    else if (round_update)
    begin
      state_reg <= round_out;
    end
  end

endmodule

`default_nettype wire

// File: src/aes_key_schedule.sv
// aes_key_schedule
// on-the-fly AES-128 key expansion, one round key per key cycle
// SubWord goes through the shared S-box word

`timescale 1ns/1ps
`default_nettype none

module aes_key_schedule
  import aes_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  reset_n,
  input  wire aes_block_t            key,
  input  wire logic                  init_cycle,
  input  wire logic                  key_cycle,
  input  wire logic [AES_WORD_W-1:0] sbox_out,
  output aes_block_t                 round_key,
  output logic      [AES_WORD_W-1:0] key_word
);

  aes_block_t            key_reg;
  aes_block_t            key_next;
  logic [7:0]            rcon_reg;
  logic [AES_WORD_W-1:0] temp_word;

  // RotWord of the last word goes to the S-box
  assign key_word = {key_reg.w[AES_NUM_WORDS-1][AES_WORD_W-9:0],
                     key_reg.w[AES_NUM_WORDS-1][AES_WORD_W-1:AES_WORD_W-8]};

  // cipher key bypass in the init cycle
  // the datapath does its initial AddRoundKey before key_reg is loaded
  assign round_key = init_cycle ? key : key_reg;

  // --------------------
  // next round key
  // --------------------
  always_comb
  begin
    // SubWord(RotWord(w3)) ^ rcon
    temp_word     = sbox_out ^ {rcon_reg, {(AES_WORD_W - 8){1'b0}}};
    key_next.w[0] = key_reg.w[0] ^ temp_word;
    // each later word chains off the new one before it
    for (int i = 1; i < AES_NUM_WORDS; i++)
    begin
      key_next.w[i] = key_reg.w[i] ^ key_next.w[i-1];
    end
  end

  // round key register, no reset
  always_ff @(posedge clk)
  begin
    if (init_cycle)
    begin
      key_reg <= key;
    end
    else if (key_cycle)
    begin
      key_reg <= key_next;
    end
  end

  // rcon register, doubled once per round
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      rcon_reg <= AES_RCON_INIT;
    end
    else if (init_cycle)
    begin
      rcon_reg <= AES_RCON_INIT;
    end
    else if (key_cycle)
    begin
      rcon_reg <= aes_xtime(rcon_reg);
    end
  end

endmodule

`default_nettype wire

// File: src/aes_sbox_word.sv
// aes_sbox_word
// four byte S-boxes on one 32-bit word, shared by the block
// SubBytes cycles and the key schedule SubWord cycle
// each byte is inverted in GF(2^8) and then affine mapped

`timescale 1ns/1ps
`default_nettype none

module aes_sbox_word
  import aes_pkg::*;
(
  input  wire logic                  key_cycle,
  input  wire logic [AES_WORD_W-1:0] block_word,
  input  wire logic [AES_WORD_W-1:0] key_word,
  output logic      [AES_WORD_W-1:0] sbox_out
);

  // --------------------
  // GF(2^8) arithmetic
  // --------------------

  // shift and add multiply
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] p;
    acc = 8'h00;
    p   = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
      begin
        acc = acc ^ p;
      end
      p = aes_xtime(p);
    end
    return acc;
  endfunction

  // inverse as a^254, zero maps to zero
  function automatic logic [7:0] gf_inv(input logic [7:0] a);
    logic [7:0] sq;
    logic [7:0] acc;
    sq  = gf_mul(a, a);
    acc = sq;
    // sq walks a^4 .. a^128, acc collects the product
    for (int i = 0; i < 6; i++)
    begin
      sq  = gf_mul(sq, sq);
      acc = gf_mul(acc, sq);
    end
    return acc;
  endfunction

  // b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 0x63
  function automatic logic [7:0] affine(input logic [7:0] b);
    return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]} ^
           {b[3:0], b[7:4]} ^ AES_AFFINE_C;
  endfunction

  // --------------------
  // word select and lookup
  // --------------------
  logic [AES_WORD_W-1:0] sbox_in;

  // key word only in the key cycle, block word otherwise
  assign sbox_in = key_cycle ? key_word : block_word;

  always_comb
  begin
    for (int i = 0; i < AES_WORD_W / 8; i++)
    begin
      sbox_out[8*i +: 8] = affine(gf_inv(sbox_in[8*i +: 8]));
    end
  end

endmodule

`default_nettype wire

// File: src/aes_pkg.sv
// aes_pkg
// shared widths, round constants, FSM state codes and the block type
// for the iterative AES-128 encipher core

`default_nettype none

package aes_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int AES_BLOCK_W   = 128;
  localparam int AES_WORD_W    = 32;
  localparam int AES_NUM_WORDS = 4;

  // one SubBytes word per cycle
  localparam int AES_SWORD_W = $clog2(AES_NUM_WORDS);

  // --------------------
  // round constants
  // --------------------
  localparam int AES128_ROUNDS = 10;
  localparam int AES_ROUND_W   = $clog2(AES128_ROUNDS);

  localparam logic [7:0] AES_RCON_INIT   = 8'h01;
  localparam logic [7:0] AES_REDUCE_POLY = 8'h1b;
  // affine constant of the S-box
  localparam logic [7:0] AES_AFFINE_C    = 8'h63;

  // --------------------
  // encipher FSM states
  // --------------------
  localparam int AES_ST_W = 3;

  localparam logic [AES_ST_W-1:0] AES_ST_IDLE   = 3'd0;
  localparam logic [AES_ST_W-1:0] AES_ST_INIT   = 3'd1;
  localparam logic [AES_ST_W-1:0] AES_ST_KEY    = 3'd2;
  localparam logic [AES_ST_W-1:0] AES_ST_SUB    = 3'd3;
  localparam logic [AES_ST_W-1:0] AES_ST_UPDATE = 3'd4;

  // 128-bit block, two views of the same bits
  // word 0 and byte 0 sit at the top, bytes run down each column
  typedef union packed {
    logic [0:AES_NUM_WORDS-1][AES_WORD_W-1:0] w;
    logic [0:AES_BLOCK_W/8-1][7:0]            b;
  } aes_block_t;

  // multiply by x in GF(2^8)
  function automatic logic [7:0] aes_xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (AES_REDUCE_POLY & {8{a[7]}});
  endfunction

endpackage

`default_nettype wire
